//--- hw/bbox_pkg.sv
//********************
// Shared types for the bounding-box pipeline
// Coordinates are signed fixed point, SIGFIG bits with RADIX fraction bits
// Screen size is given as a vertex with the upper right pixel corner
// MSAA codes are one-hot; any other code acts as 1x downstream
//********************
`default_nettype none

package bbox_pkg;

    // Fixed-point format of every coordinate
    localparam int SIGFIG = 24;
    localparam int RADIX = 10;

    // Facing test widths
    // One extra bit holds any edge difference exactly
    localparam int DIFF_W = SIGFIG + 1;
    // Product of two differences plus one bit for the subtraction
    localparam int AREA_W = 2 * DIFF_W + 1;

    // One-hot MSAA selection, MSB is a single sample per pixel
    typedef logic [3:0] msaa_t;

    // Sample grid of 1, 4, 16 and 64 samples per pixel
    localparam msaa_t MSAA_1X = 4'b1000;
    localparam msaa_t MSAA_4X = 4'b0100;
    localparam msaa_t MSAA_16X = 4'b0010;
    localparam msaa_t MSAA_64X = 4'b0001;

    // One fixed-point coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Edge difference and signed area of the facing test
    typedef logic signed [DIFF_W-1:0] diff_t;
    typedef logic signed [AREA_W-1:0] area_t;

    // x,y pair, also used for the screen size
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Triangle as three vertices in submission order
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        vertex_t ll;
        vertex_t ur;
    } box_t;

    // Contents of one pipeline stage
    // The triangle rides along with its box
    // box is meaningless when valid is low
    typedef struct packed {
        logic valid;
        tri_t tri_data;
        box_t box;
    } bbox_item_t;

endpackage

`default_nettype wire

//--- hw/bbox_extent.sv
//********************
// Stage 1 of the bounding-box pipeline
// Back-facing test uses the full-width signed area, no truncation
// Positive area means back-facing and clears valid
// Box is the per-axis min/max of the vertices, not yet snapped
// All stage state holds while halt is high
//********************
`default_nettype none

module bbox_extent (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 halt,
    input  bbox_pkg::tri_t       tri_in,
    input  logic                 tri_valid,
    output bbox_pkg::bbox_item_t stage1_item
);

    // Smallest of three signed coordinates
    function automatic bbox_pkg::coord_t min3(
        input bbox_pkg::coord_t a,
        input bbox_pkg::coord_t b,
        input bbox_pkg::coord_t c
    );
        bbox_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    // Largest of three signed coordinates
    function automatic bbox_pkg::coord_t max3(
        input bbox_pkg::coord_t a,
        input bbox_pkg::coord_t b,
        input bbox_pkg::coord_t c
    );
        bbox_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Edge differences, one bit wider than a coordinate
    bbox_pkg::diff_t dx0;
    bbox_pkg::diff_t dx1;
    bbox_pkg::diff_t dy0;
    bbox_pkg::diff_t dy1;

    // Signed area term of the winding
    bbox_pkg::area_t area;
    logic back_face;

    // Next contents of stage 1
    bbox_pkg::bbox_item_t next_item;

    // Facing test
    always_comb begin
        // Edge v0->v1 and v1->v2 along x
        dx0 = bbox_pkg::diff_t'(tri_in.v1.x) - bbox_pkg::diff_t'(tri_in.v0.x);
        dx1 = bbox_pkg::diff_t'(tri_in.v2.x) - bbox_pkg::diff_t'(tri_in.v1.x);
        // Edge v1->v2 and v0->v1 along y
        dy0 = bbox_pkg::diff_t'(tri_in.v2.y) - bbox_pkg::diff_t'(tri_in.v1.y);
        dy1 = bbox_pkg::diff_t'(tri_in.v1.y) - bbox_pkg::diff_t'(tri_in.v0.y);
        // Operands sign-extend to the area width before multiplying
        area = bbox_pkg::area_t'(dx0) * bbox_pkg::area_t'(dy0)
             - bbox_pkg::area_t'(dx1) * bbox_pkg::area_t'(dy1);
        back_face = (area > 0);
    end

    // Extent selection and valid
    always_comb begin
        next_item.valid = tri_valid & ~back_face;
        next_item.tri_data = tri_in;
        // Lower left from the minima
        next_item.box.ll.x = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        next_item.box.ll.y = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
        // Upper right from the maxima
        next_item.box.ur.x = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        next_item.box.ur.y = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
    end

    // Stage 1 register
    always_ff @(posedge clk) begin
        if (reset) begin
            stage1_item <= '0;
        end else if (!halt) begin
            stage1_item <= next_item;
        end
        // Halted edges keep the held item
    end

endmodule

`default_nettype wire

//--- hw/bbox_snap.sv
//********************
// Stage 2 of the bounding-box pipeline
// Floors both corners to the subsample grid chosen by msaa
// Unknown msaa codes fall back to whole pixels
// msaa must stay steady while items are in flight
//********************
`default_nettype none

module bbox_snap (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 halt,
    input  bbox_pkg::msaa_t      msaa,
    input  bbox_pkg::bbox_item_t stage1_item,
    output bbox_pkg::bbox_item_t stage2_item
);

    // Fraction bits kept by the grid, 0 to 3
    logic [1:0] frac_keep;

    // Ones over the integer part and the kept fraction bits
    bbox_pkg::coord_t snap_mask;

    // Next contents of stage 2
    bbox_pkg::bbox_item_t next_item;

    // MSAA decode to a coordinate mask
    always_comb begin
        case (msaa)
            bbox_pkg::MSAA_4X: frac_keep = 2'd1;
            bbox_pkg::MSAA_16X: frac_keep = 2'd2;
            bbox_pkg::MSAA_64X: frac_keep = 2'd3;
            // MSAA_1X and any malformed code
            default: frac_keep = 2'd0;
        endcase
        snap_mask = {bbox_pkg::SIGFIG{1'b1}} << (bbox_pkg::RADIX - int'(frac_keep));
    end

    // Floor of every corner coordinate
    always_comb begin
        next_item = stage1_item;
        // Clearing low bits rounds toward minus infinity, also for negatives
        next_item.box.ll.x = stage1_item.box.ll.x & snap_mask;
        next_item.box.ll.y = stage1_item.box.ll.y & snap_mask;
        next_item.box.ur.x = stage1_item.box.ur.x & snap_mask;
        next_item.box.ur.y = stage1_item.box.ur.y & snap_mask;
    end

    // Stage 2 register
    always_ff @(posedge clk) begin
        if (reset) begin
            stage2_item <= '0;
        end else if (!halt) begin
            stage2_item <= next_item;
        end
    end

endmodule

`default_nettype wire

//--- hw/bbox_clip.sv
//********************
// Stage 3 of the bounding-box pipeline, the output stage
// Rejects boxes wholly outside 0..screen on either axis
// Clamps ll up to 0 and ur down to the screen size
// Box of a rejected item is not meaningful
// screen must stay steady while items are in flight
//********************
`default_nettype none

module bbox_clip (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 halt,
    input  bbox_pkg::vertex_t    screen,
    input  bbox_pkg::bbox_item_t stage2_item,
    output bbox_pkg::bbox_item_t out_item
);

    // Snapped box from stage 2
    bbox_pkg::box_t snapped;

    // Box after clamping to the screen
    bbox_pkg::box_t clamped;

    // Off-screen detection per axis
    logic reject_x;
    logic reject_y;

    // Next contents of the output stage
    bbox_pkg::bbox_item_t next_item;

    // Rejection
    always_comb begin
        snapped = stage2_item.box;
        // Left of the origin or right of the screen
        reject_x = (snapped.ur.x < 0) | (snapped.ll.x > screen.x);
        // Below the origin or above the screen
        reject_y = (snapped.ur.y < 0) | (snapped.ll.y > screen.y);
    end

    // Clamping
    always_comb begin
        // Lower left no smaller than the origin
        if (snapped.ll.x < 0) begin
            clamped.ll.x = bbox_pkg::coord_t'(0);
        end else begin
            clamped.ll.x = snapped.ll.x;
        end
        if (snapped.ll.y < 0) begin
            clamped.ll.y = bbox_pkg::coord_t'(0);
        end else begin
            clamped.ll.y = snapped.ll.y;
        end
        // Upper right no larger than the screen
        if (snapped.ur.x > screen.x) begin
            clamped.ur.x = screen.x;
        end else begin
            clamped.ur.x = snapped.ur.x;
        end
        if (snapped.ur.y > screen.y) begin
            clamped.ur.y = screen.y;
        end else begin
            clamped.ur.y = snapped.ur.y;
        end
    end

    // Output item
    always_comb begin
        next_item.valid = stage2_item.valid & ~reject_x & ~reject_y;
        next_item.tri_data = stage2_item.tri_data;
        next_item.box = clamped;
    end

    // Output register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_item <= '0;
        end else if (!halt) begin
            out_item <= next_item;
        end
    end

endmodule

`default_nettype wire

//--- hw/bbox_top.sv
//********************
// Bounding-box stage of the rasterizer, three pipeline stages
// One triangle is taken on every edge with halt low, no handshake
// Result appears after three advancing edges
// halt freezes all stages and the input is ignored
// screen and msaa are levels, steady while items are in flight
//********************
`default_nettype none

module bbox_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 halt,
    input  logic                 tri_valid,
    input  bbox_pkg::tri_t       tri_in,
    input  bbox_pkg::vertex_t    screen,
    input  bbox_pkg::msaa_t      msaa,
    output bbox_pkg::bbox_item_t out_item
);

    // Item after facing test and extent
    bbox_pkg::bbox_item_t stage1_item;

    // Item after snapping to the sample grid
    bbox_pkg::bbox_item_t stage2_item;

    // Stage 1, facing test and min/max box
    bbox_extent u_extent (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .tri_in      (tri_in),
        .tri_valid   (tri_valid),
        .stage1_item (stage1_item)
    );

    // Stage 2, only this stage sees msaa
    bbox_snap u_snap (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .msaa        (msaa),
        .stage1_item (stage1_item),
        .stage2_item (stage2_item)
    );

    // Stage 3, clamp and reject against the screen
    bbox_clip u_clip (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .screen      (screen),
        .stage2_item (stage2_item),
        .out_item    (out_item)
    );

endmodule

`default_nettype wire

//--- verif/bbox_chk.sv
//********************
// Output checker for the bounding-box pipeline, bound into bbox_top
// Assumes screen is steady while items are in flight
// Box bounds are checked for valid items only
//********************
`default_nettype none

module bbox_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 halt,
    input bbox_pkg::vertex_t    screen,
    input bbox_pkg::bbox_item_t out_item
);
    timeunit 1ns;
    timeprecision 1ps;

    // Valid box is ordered and lies inside 0..screen
    property box_in_screen;
        @(posedge clk) disable iff (reset)
        out_item.valid |->
            (out_item.box.ll.x <= out_item.box.ur.x) &&
            (out_item.box.ll.y <= out_item.box.ur.y) &&
            (out_item.box.ll.x >= 0) && (out_item.box.ll.y >= 0) &&
            (out_item.box.ur.x <= screen.x) && (out_item.box.ur.y <= screen.y);
    endproperty

    // Reset empties the output stage on the next edge
    property cleared_by_reset;
        @(posedge clk) reset |=> !out_item.valid;
    endproperty

    // Halted edge leaves the output untouched
    property held_on_halt;
        @(posedge clk) disable iff (reset)
        halt |=> $stable(out_item);
    endproperty

    a_box_in_screen: assert property (box_in_screen)
        else $error("Valid output box is out of order or off screen");
    a_cleared_by_reset: assert property (cleared_by_reset)
        else $error("Output valid still set after reset");
    a_held_on_halt: assert property (held_on_halt)
        else $error("Output changed across a halted edge");

endmodule

// One checker per bbox_top instance
bind bbox_top bbox_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .halt     (halt),
    .screen   (screen),
    .out_item (out_item)
);

`default_nettype wire

//--- verif/bbox_tb.sv
//********************
// Testbench for the bounding-box pipeline
// Expected boxes are worked by hand from the facing, snap and clip rules
// Screen is fixed at 640x480 pixels for every row
// msaa changes only after a tri_valid 0 row, since snap sees the next row's code
// Second pass halts the pipeline from one LFSR bit per cycle
//********************
`default_nettype none

module bbox_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles a row may wait under halt
    localparam int HALT_TIMEOUT = 64;
    // Cycles allowed for the pipeline to empty at the end
    localparam int DRAIN_TIMEOUT = 32;
    localparam logic [31:0] LFSR_SEED = 32'h2c29305d;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // One table row, stimulus and expected result
    typedef struct packed {
        bbox_pkg::tri_t    tri_data;
        logic              tri_valid;
        bbox_pkg::msaa_t   msaa;
        bbox_pkg::vertex_t screen;
        logic              exp_valid;
        bbox_pkg::box_t    exp_box;
    } row_t;

    // DUT ports
    logic clk = 1'b0;
    logic reset;
    logic halt;
    logic tri_valid;
    bbox_pkg::tri_t tri_in;
    bbox_pkg::vertex_t screen;
    bbox_pkg::msaa_t msaa;
    bbox_pkg::bbox_item_t out_item;

    row_t table_rows[$];
    // Row index held by each stage, -1 for an empty stage
    int pipe_idx[3];
    // Row currently on the inputs
    int drv_entry;
    // Table rows that have reached the output
    int seen_count;
    int mismatch_count;
    int other_errors;
    logic aborted;
    logic [31:0] lfsr;
    bbox_pkg::vertex_t screen_size;

    bbox_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .halt      (halt),
        .tri_valid (tri_valid),
        .tri_in    (tri_in),
        .screen    (screen),
        .msaa      (msaa),
        .out_item  (out_item)
    );

    always #20 clk = ~clk;

    // Whole pixels plus a fraction in 1/1024 steps
    function automatic bbox_pkg::coord_t to_fixed(input int whole, input int frac);
        return bbox_pkg::coord_t'(whole * (1 << bbox_pkg::RADIX) + frac);
    endfunction

    function automatic bbox_pkg::vertex_t make_vertex(input bbox_pkg::coord_t x,
                                                      input bbox_pkg::coord_t y);
        bbox_pkg::vertex_t v;
        v.x = x;
        v.y = y;
        return v;
    endfunction

    function automatic bbox_pkg::vertex_t pixel_vertex(input int x, input int y);
        return make_vertex(to_fixed(x, 0), to_fixed(y, 0));
    endfunction

    function automatic bbox_pkg::tri_t make_tri(input bbox_pkg::vertex_t a,
                                                input bbox_pkg::vertex_t b,
                                                input bbox_pkg::vertex_t c);
        bbox_pkg::tri_t t;
        t.v0 = a;
        t.v1 = b;
        t.v2 = c;
        return t;
    endfunction

    function automatic bbox_pkg::box_t make_box(input bbox_pkg::vertex_t ll,
                                                input bbox_pkg::vertex_t ur);
        bbox_pkg::box_t b;
        b.ll = ll;
        b.ur = ur;
        return b;
    endfunction

    // Right-shifting Galois LFSR, new bit lands in bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic add_row(input bbox_pkg::tri_t t, input logic tv,
                           input bbox_pkg::msaa_t m, input logic ev,
                           input bbox_pkg::box_t eb);
        row_t r;
        r.tri_data = t;
        r.tri_valid = tv;
        r.msaa = m;
        r.screen = screen_size;
        r.exp_valid = ev;
        r.exp_box = eb;
        table_rows.push_back(r);
    endtask

    task automatic build_table();
        bbox_pkg::tri_t base_tri;
        bbox_pkg::tri_t snap_tri;
        screen_size = pixel_vertex(640, 480);
        base_tri = make_tri(pixel_vertex(10, 20), pixel_vertex(30, 60), pixel_vertex(50, 25));
        // Fraction bits 3a5, 2e1 at the minima and 0ff, 1c7 at the maxima
        snap_tri = make_tri(make_vertex(to_fixed(10, 'h3a5), to_fixed(20, 'h2e1)),
                            make_vertex(to_fixed(30, 'h100), to_fixed(60, 'h1c7)),
                            make_vertex(to_fixed(50, 'h0ff), to_fixed(25, 'h010)));
        // Clockwise winding gives negative area, then the reversed winding
        add_row(base_tri, 1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(10, 20), pixel_vertex(50, 60)));
        add_row(make_tri(pixel_vertex(10, 20), pixel_vertex(50, 25), pixel_vertex(30, 60)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        add_row(make_tri(pixel_vertex(100, 200), pixel_vertex(120, 300), pixel_vertex(400, 150)),
                1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(100, 150), pixel_vertex(400, 300)));
        add_row(make_tri(pixel_vertex(100, 200), pixel_vertex(400, 150), pixel_vertex(120, 300)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        // Straddles the origin and the top edge
        add_row(make_tri(pixel_vertex(-5, -8), pixel_vertex(20, 500), pixel_vertex(60, 10)),
                1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(0, 0), pixel_vertex(60, 480)));
        // Straddles the right edge
        add_row(make_tri(pixel_vertex(600, 400), pixel_vertex(620, 470), pixel_vertex(700, 300)),
                1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(600, 300), pixel_vertex(640, 470)));
        // Wholly left, below, right and above
        add_row(make_tri(pixel_vertex(-50, 20), pixel_vertex(-30, 60), pixel_vertex(-10, 25)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        add_row(make_tri(pixel_vertex(10, -80), pixel_vertex(30, -40), pixel_vertex(50, -75)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        add_row(make_tri(pixel_vertex(700, 20), pixel_vertex(720, 60), pixel_vertex(740, 25)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        add_row(make_tri(pixel_vertex(10, 500), pixel_vertex(30, 540), pixel_vertex(50, 505)),
                1'b1, bbox_pkg::MSAA_1X, 1'b0, '0);
        // ll.x on the right edge and ur.x on the origin still pass
        add_row(make_tri(pixel_vertex(640, 20), pixel_vertex(660, 60), pixel_vertex(680, 25)),
                1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(640, 20), pixel_vertex(640, 60)));
        add_row(make_tri(pixel_vertex(-40, 20), pixel_vertex(-20, 60), pixel_vertex(0, 25)),
                1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(0, 20), pixel_vertex(0, 60)));
        add_row(base_tri, 1'b0, bbox_pkg::MSAA_1X, 1'b0, '0);
        // Same fractional triangle at 4x, 16x, 64x and 1x
        add_row(snap_tri, 1'b1, bbox_pkg::MSAA_4X, 1'b1,
                make_box(make_vertex(to_fixed(10, 'h200), to_fixed(20, 'h200)),
                         make_vertex(to_fixed(50, 'h000), to_fixed(60, 'h000))));
        add_row(snap_tri, 1'b0, bbox_pkg::MSAA_4X, 1'b0, '0);
        add_row(snap_tri, 1'b1, bbox_pkg::MSAA_16X, 1'b1,
                make_box(make_vertex(to_fixed(10, 'h300), to_fixed(20, 'h200)),
                         make_vertex(to_fixed(50, 'h000), to_fixed(60, 'h100))));
        add_row(snap_tri, 1'b0, bbox_pkg::MSAA_16X, 1'b0, '0);
        add_row(snap_tri, 1'b1, bbox_pkg::MSAA_64X, 1'b1,
                make_box(make_vertex(to_fixed(10, 'h380), to_fixed(20, 'h280)),
                         make_vertex(to_fixed(50, 'h080), to_fixed(60, 'h180))));
        add_row(snap_tri, 1'b0, bbox_pkg::MSAA_64X, 1'b0, '0);
        add_row(snap_tri, 1'b1, bbox_pkg::MSAA_1X, 1'b1,
                make_box(pixel_vertex(10, 20), pixel_vertex(50, 60)));
    endtask

    task automatic compare(input string name, input logic [47:0] expected,
                           input logic [47:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
            mismatch_count++;
        end
    endtask

    task automatic check_output();
        row_t r;
        if (pipe_idx[2] < 0) begin
            // Empty stage, nothing valid may leave
            compare("out_item.valid", 48'(1'b0), 48'(out_item.valid));
        end else begin
            r = table_rows[pipe_idx[2]];
            compare("out_item.valid", 48'(r.exp_valid), 48'(out_item.valid));
            compare("out_item.tri_data.v0", r.tri_data.v0, out_item.tri_data.v0);
            compare("out_item.tri_data.v1", r.tri_data.v1, out_item.tri_data.v1);
            compare("out_item.tri_data.v2", r.tri_data.v2, out_item.tri_data.v2);
            // Rejected items carry a meaningless box
            if (r.exp_valid) begin
                compare("out_item.box.ll", r.exp_box.ll, out_item.box.ll);
                compare("out_item.box.ur", r.exp_box.ur, out_item.box.ur);
            end
        end
    endtask

    task automatic drive_inputs(input int entry, input logic halt_val);
        row_t r;
        halt = halt_val;
        drv_entry = entry;
        if (entry < 0) begin
            // Bubble keeps msaa and screen as they were
            tri_valid = 1'b0;
            tri_in = '0;
        end else begin
            r = table_rows[entry];
            tri_in = r.tri_data;
            tri_valid = r.tri_valid;
            msaa = r.msaa;
            screen = r.screen;
        end
    endtask

    // One clock cycle, outputs are checked at the falling edge
    task automatic step(input int entry, input logic halt_val);
        @(negedge clk);
        // Model follows the rising edge just passed
        if (!halt) begin
            pipe_idx[2] = pipe_idx[1];
            pipe_idx[1] = pipe_idx[0];
            pipe_idx[0] = drv_entry;
            if (pipe_idx[2] >= 0) begin
                seen_count++;
            end
        end
        check_output();
        drive_inputs(entry, halt_val);
    endtask

    // Hold one row on the inputs until an edge with halt low takes it
    task automatic apply_row(input int idx, input logic use_halt);
        int waited;
        logic h;
        waited = 0;
        h = 1'b1;
        while (h && !aborted) begin
            if (waited >= HALT_TIMEOUT) begin
                $display("Timeout: row %0d was not taken within %0d cycles",
                         idx, HALT_TIMEOUT);
                other_errors++;
                aborted = 1'b1;
            end else begin
                h = 1'b0;
                if (use_halt) begin
                    lfsr = lfsr_step(lfsr);
                    h = lfsr[0];
                end
                step(idx, h);
                waited++;
            end
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while ((seen_count < 2 * table_rows.size()) && !aborted) begin
            if (waited >= DRAIN_TIMEOUT) begin
                $display("Timeout: pipeline did not drain within %0d cycles", DRAIN_TIMEOUT);
                other_errors++;
                aborted = 1'b1;
            end else begin
                step(-1, 1'b0);
                waited++;
            end
        end
    endtask

    initial begin
        mismatch_count = 0;
        other_errors = 0;
        seen_count = 0;
        aborted = 1'b0;
        lfsr = LFSR_SEED;
        drv_entry = -1;
        pipe_idx[0] = -1;
        pipe_idx[1] = -1;
        pipe_idx[2] = -1;
        build_table();
        reset = 1'b1;
        halt = 1'b0;
        tri_valid = 1'b0;
        tri_in = '0;
        screen = screen_size;
        msaa = bbox_pkg::MSAA_1X;
        // Three reset edges, output stays empty
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_output();
        end
        reset = 1'b0;
        // First pass free running, second pass under random halt
        for (int pass_num = 0; pass_num < 2; pass_num++) begin
            for (int i = 0; i < table_rows.size(); i++) begin
                if (!aborted) begin
                    apply_row(i, pass_num == 1);
                end
            end
        end
        drain_pipeline();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if ((mismatch_count == 0) && (other_errors == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/bbox_pkg.sv
hw/bbox_extent.sv
hw/bbox_snap.sv
hw/bbox_clip.sv
hw/bbox_top.sv
verif/bbox_chk.sv
verif/bbox_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = bbox_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

# Build, run and look for the pass line in the output
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
